// File: alu.sv
`include "rv_cfg.svh"

module alu (
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] imm,
    ctrl_if.dp               c,
    output logic [`XLEN-1:0] result,
    output logic             take_branch
);
    import rv_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] raw;

    always_comb begin
        op_a = rs1_data;
        op_b = rs2_data;
        case (c.alu_src)
            SRC_IMM:    op_b = imm;
            SRC_PC4: begin
                op_a = pc;                  // link value
                op_b = `XLEN'(4);
            end
            SRC_PC_IMM: begin
                op_a = pc;
                op_b = imm;
            end
            default:    op_b = rs2_data;
        endcase
    end

    always_comb begin
        case (c.alu_op)
            ALU_SUB:  raw = op_a - op_b;
            ALU_SLTU: raw = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_SRA:  raw = $signed(op_a) >>> op_b[5:0];
            default:  raw = op_a + op_b;
        endcase
        result = c.word_op ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;
    end

    assign take_branch = c.branch & ((rs1_data == rs2_data) ^ c.branch_ne);

endmodule

// File: ctrl.sv
module ctrl (
    input  rv_pkg::inst_t inst,
    output logic          illegal,
    output logic          ebreak,
    ctrl_if.dec           c
);
    import rv_pkg::*;

    always_comb begin
        c.reg_wen    = 1'b0;
        c.rs1_addr   = inst.r.rs1;
        c.rs2_addr   = inst.r.rs2;
        c.rd_addr    = inst.r.rd;
        c.imm_sel    = IMM_I;
        c.alu_op     = ALU_ADD;
        c.alu_src    = SRC_REG;
        c.word_op    = 1'b0;
        c.mem_wen    = 1'b0;
        c.mem_ren    = 1'b0;
        c.mem_size   = MEM_D;
        c.mem_signed = 1'b0;
        c.branch     = 1'b0;
        c.branch_ne  = 1'b0;
        c.jump       = 1'b0;
        c.jalr       = 1'b0;
        c.wb_sel     = WB_ALU;
        illegal      = 1'b0;
        ebreak       = 1'b0;
        case (inst.r.opcode)
            OP_REG, OP_REGW: begin
                c.word_op = (inst.r.opcode == OP_REGW);
                if (inst.r.funct3 == 3'b000 && inst.r.funct7 == 7'b0000000) begin
                    c.reg_wen = 1'b1;               // add, addw
                end else if (inst.r.funct3 == 3'b000 && inst.r.funct7 == 7'b0100000
                             && inst.r.opcode == OP_REG) begin
                    c.reg_wen = 1'b1;               // sub
                    c.alu_op  = ALU_SUB;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_IMM: begin
                c.alu_src = SRC_IMM;
                if (inst.i.funct3 == 3'b000) begin
                    c.reg_wen = 1'b1;               // addi
                end else if (inst.i.funct3 == 3'b011) begin
                    c.reg_wen = 1'b1;               // sltiu
                    c.alu_op  = ALU_SLTU;
                end else if (inst.i.funct3 == 3'b101 && inst.r.funct7[6:1] == 6'b010000) begin
                    c.reg_wen = 1'b1;               // srai, 6-bit shamt
                    c.alu_op  = ALU_SRA;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_IMMW: begin
                c.alu_src = SRC_IMM;
                c.word_op = 1'b1;
                c.reg_wen = (inst.i.funct3 == 3'b000);
                illegal   = (inst.i.funct3 != 3'b000);
            end
            OP_LOAD: begin
                c.alu_src    = SRC_IMM;
                c.wb_sel     = WB_MEM;
                c.mem_signed = 1'b1;
                c.mem_size   = (inst.i.funct3 == 3'b010) ? MEM_W : MEM_D;
                c.mem_ren    = (inst.i.funct3 == 3'b010 || inst.i.funct3 == 3'b011);
                c.reg_wen    = c.mem_ren;
                illegal      = !c.mem_ren;
            end
            OP_STORE: begin
                c.imm_sel  = IMM_S;
                c.alu_src  = SRC_IMM;
                c.mem_size = (inst.s.funct3 == 3'b001) ? MEM_H : MEM_D;
                c.mem_wen  = (inst.s.funct3 == 3'b001 || inst.s.funct3 == 3'b011);
                illegal    = !c.mem_wen;
            end
            OP_BRANCH: begin
                c.imm_sel   = IMM_B;
                c.branch_ne = inst.b.funct3[0];
                c.branch    = (inst.b.funct3[2:1] == 2'b00);   // beq, bne
                illegal     = !c.branch;
            end
            OP_JAL: begin
                c.reg_wen = 1'b1;
                c.imm_sel = IMM_J;
                c.alu_src = SRC_PC4;
                c.jump    = 1'b1;
            end
            OP_JALR: begin
                c.alu_src = SRC_PC4;
                c.jump    = (inst.i.funct3 == 3'b000);
                c.jalr    = c.jump;
                c.reg_wen = c.jump;
                illegal   = !c.jump;
            end
            OP_LUI: begin
                c.reg_wen  = 1'b1;
                c.rs1_addr = '0;                    // x0 + imm
                c.imm_sel  = IMM_U;
                c.alu_src  = SRC_IMM;
            end
            OP_AUIPC: begin
                c.reg_wen = 1'b1;
                c.imm_sel = IMM_U;
                c.alu_src = SRC_PC_IMM;
            end
            OP_SYSTEM: begin
                ebreak  = (inst == 32'h0010_0073);
                illegal = !ebreak;
            end
            default: illegal = 1'b1;
        endcase
    end

    // a rejected encoding must never reach the register file
    always_comb begin
        a_no_write_on_illegal: assert (!(illegal && c.reg_wen))
            else $error("illegal encoding %h decoded with reg_wen", inst);
    end

endmodule

// File: ctrl_if.sv
`include "rv_cfg.svh"

interface ctrl_if;
    import rv_pkg::*;

    logic                      reg_wen;
    logic [$clog2(`NREGS)-1:0] rs1_addr;
    logic [$clog2(`NREGS)-1:0] rs2_addr;
    logic [$clog2(`NREGS)-1:0] rd_addr;
    imm_sel_e                  imm_sel;
    alu_op_e                   alu_op;
    alu_src_e                  alu_src;
    logic                      word_op;    // sign-extend low 32 bits of result
    logic                      mem_wen;
    logic                      mem_ren;
    mem_size_e                 mem_size;
    logic                      mem_signed;
    logic                      branch;
    logic                      branch_ne;
    logic                      jump;
    logic                      jalr;
    wb_sel_e                   wb_sel;

    modport dec (
        output reg_wen, rs1_addr, rs2_addr, rd_addr, imm_sel, alu_op, alu_src, word_op,
               mem_wen, mem_ren, mem_size, mem_signed, branch, branch_ne, jump, jalr, wb_sel
    );

    modport dp (
        input  reg_wen, rs1_addr, rs2_addr, rd_addr, imm_sel, alu_op, alu_src, word_op,
               mem_wen, mem_ren, mem_size, mem_signed, branch, branch_ne, jump, jalr, wb_sel
    );

endinterface

// File: imm_gen.sv
`include "rv_cfg.svh"

module imm_gen (
    input  rv_pkg::inst_t     inst,
    ctrl_if.dp                c,
    output logic [`XLEN-1:0]  imm
);
    import rv_pkg::*;

    always_comb begin
        case (c.imm_sel)
            IMM_I: imm = {{(`XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            IMM_S: imm = {{(`XLEN-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            IMM_B: begin
                imm = {{(`XLEN-12){inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                       inst.b.imm_4_1, 1'b0};
            end
            IMM_U: imm = {{(`XLEN-32){inst.u.imm_31_12[19]}}, inst.u.imm_31_12, 12'b0};
            IMM_J: begin
                imm = {{(`XLEN-20){inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                       inst.j.imm_10_1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// File: lsu_mem.sv
`include "rv_cfg.svh"

module lsu_mem (
    input  logic             clk,
    input  logic             we,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] wdata,
    ctrl_if.dp               c,
    output logic [`XLEN-1:0] rdata
);
    import rv_pkg::*;

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [AW-1:0]    widx;
    logic [2:0]       boff;
    logic [7:0]       bmask;
    logic [2:0]       align_mask;
    logic [`XLEN-1:0] wlane;      // store data moved into its byte lanes
    logic [`XLEN-1:0] rshift;

    assign widx = addr[AW+2:3];
    assign boff = addr[2:0];

    always_comb begin
        case (c.mem_size)
            MEM_H: begin
                bmask      = 8'b0000_0011 << boff;
                align_mask = 3'b001;
            end
            MEM_W: begin
                bmask      = 8'b0000_1111 << boff;
                align_mask = 3'b011;
            end
            default: begin
                bmask      = 8'hff;
                align_mask = 3'b111;
            end
        endcase
    end

    assign wlane = wdata << {boff, 3'b000};

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 8; b++) begin
                if (bmask[b]) begin
                    mem[widx][b*8 +: 8] <= wlane[b*8 +: 8];
                end
            end
        end
    end

    assign rshift = mem[widx] >> {boff, 3'b000};

    always_comb begin
        case (c.mem_size)
            MEM_H:   rdata = {{(`XLEN-16){c.mem_signed & rshift[15]}}, rshift[15:0]};
            MEM_W:   rdata = {{(`XLEN-32){c.mem_signed & rshift[31]}}, rshift[31:0]};
            default: rdata = rshift;
        endcase
    end

    a_aligned: assert property (
        @(posedge clk) (we || c.mem_ren) |-> ((boff & align_mask) == 3'b000)
    ) else $error("misaligned access at %h", addr);

endmodule

// File: regfile.sv
`include "rv_cfg.svh"

module regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             we,
    input  logic [`XLEN-1:0] wdata,
    ctrl_if.dp               c,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [`NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && c.rd_addr != '0) begin     // x0 writes dropped
            regs[c.rd_addr] <= wdata;
        end
    end

    assign rs1_data = regs[c.rs1_addr];
    assign rs2_data = regs[c.rs2_addr];

    // x0 reads zero on both ports, whatever was committed before
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((c.rs1_addr == '0) |-> (rs1_data == '0)) and
        ((c.rs2_addr == '0) |-> (rs2_data == '0))
    ) else $error("x0 read back nonzero");

endmodule

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f src.f --top-module tb_top
./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log

if grep -q "Regression passed" sim.log; then
    echo "simulation log shows a pass"
else
    echo "simulation log shows no pass"
    exit 1
fi

// File: rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// machine word width
`define XLEN 64

// architectural registers x0..x31
`define NREGS 32

// first fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

// data ram depth in 64-bit words
`define DMEM_WORDS 256

`endif

// File: rv_core.sv
`include "rv_cfg.svh"

module rv_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               inst,
    output logic [`XLEN-1:0]          pc,
    output logic                      halted,
    output logic                      illegal,
    output logic                      retire_valid,
    output logic [$clog2(`NREGS)-1:0] retire_rd,
    output logic [`XLEN-1:0]          retire_data
);
    import rv_pkg::*;

    ctrl_if cif ();

    logic             dec_illegal;
    logic             ebreak;
    logic             commit;     // an instruction retires at this edge
    logic             reg_we;
    logic             mem_we;
    logic             take_branch;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] ea;         // rs1 + imm, data address and jalr target
    logic [`XLEN-1:0] wb_data;
    logic [`XLEN-1:0] next_pc;

    ctrl u_ctrl (.inst(inst), .illegal(dec_illegal), .ebreak(ebreak), .c(cif));

    imm_gen u_imm_gen (.inst(inst), .c(cif), .imm(imm));

    alu u_alu (
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .c(cif), .result(alu_result), .take_branch(take_branch)
    );

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .we(reg_we), .wdata(wb_data),
        .c(cif), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    lsu_mem u_lsu_mem (
        .clk(clk), .we(mem_we), .addr(ea), .wdata(rs2_data), .c(cif), .rdata(load_data)
    );

    assign commit  = rst_n && !halted && !dec_illegal;
    assign reg_we  = commit && cif.reg_wen;
    assign mem_we  = commit && cif.mem_wen;
    assign ea      = rs1_data + imm;
    assign wb_data = (cif.wb_sel == WB_MEM) ? load_data : alu_result;

    always_comb begin
        if (cif.jalr) begin
            next_pc = {ea[`XLEN-1:1], 1'b0};
        end else if (take_branch || cif.jump) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + `XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            if (ebreak || dec_illegal) begin
                halted <= 1'b1;         // pc stays on the stopping instruction
            end else begin
                pc <= next_pc;
            end
        end
    end

    assign illegal      = rst_n && dec_illegal;
    assign retire_valid = reg_we && (cif.rd_addr != '0);
    assign retire_rd    = cif.rd_addr;
    assign retire_data  = wb_data;

endmodule

// File: rv_pkg.sv
package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one fetched word, viewed through each format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_IMMW   = 7'b0011011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_REGW   = 7'b0111011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_SLTU, ALU_SRA} alu_op_e;

    // operand b and the base it is added to
    typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_PC4, SRC_PC_IMM} alu_src_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    // value is log2 of the access size in bytes
    typedef enum logic [1:0] {MEM_H = 2'd1, MEM_W = 2'd2, MEM_D = 2'd3} mem_size_e;

    typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

endpackage

// File: src.f
+incdir+.
rv_pkg.sv
ctrl_if.sv
ctrl.sv
imm_gen.sv
alu.sv
regfile.sv
lsu_mem.sv
rv_core.sv
tb_model.sv
tb_top.sv

// File: tb_model.sv
`include "rv_cfg.svh"

module tb_model (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [31:0]      inst,
    input  logic [`XLEN-1:0] pc,
    input  logic             halted,
    input  logic             illegal,
    input  logic             retire_valid,
    input  logic [4:0]       retire_rd,
    input  logic [`XLEN-1:0] retire_data,
    output int               errors
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAW = $clog2(`DMEM_WORDS) + 3;    // byte address bits

    logic [`XLEN-1:0] sregs [`NREGS];
    logic [7:0]       smem [2**MAW];
    logic [`XLEN-1:0] spc;
    logic             shalt;
    logic             was_reset;                     // rst_n low at the last edge
    logic [6:0]       opc;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [4:0]       rd;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] immi;
    logic [`XLEN-1:0] imms;
    logic [`XLEN-1:0] immb;
    logic [`XLEN-1:0] immu;
    logic [`XLEN-1:0] immj;
    logic [`XLEN-1:0] ea;
    logic             e_wen;
    logic             e_ill;
    logic             e_brk;
    logic             e_st;
    logic             e_valid;
    int               st_bytes;
    logic [`XLEN-1:0] e_data;
    logic [`XLEN-1:0] e_npc;

    function automatic logic [63:0] sext32(input logic [63:0] v);
        return {{32{v[31]}}, v[31:0]};
    endfunction

    function automatic logic [63:0] read_dword(input logic [63:0] addr);
        logic [63:0] v;
        for (int k = 0; k < 8; k++) begin
            v[k*8 +: 8] = smem[MAW'(addr + 64'(k))];
        end
        return v;
    endfunction

    always_comb begin
        opc      = inst[6:0];
        rd       = inst[11:7];
        f3       = inst[14:12];
        f7       = inst[31:25];
        a        = sregs[inst[19:15]];
        b        = sregs[inst[24:20]];
        immi     = {{52{inst[31]}}, inst[31:20]};
        imms     = {{52{inst[31]}}, inst[31:25], inst[11:7]};
        immb     = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        immu     = {{32{inst[31]}}, inst[31:12], 12'b0};
        immj     = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        ea       = a + (opc == 7'b0100011 ? imms : immi);
        e_wen    = 1'b0;
        e_ill    = 1'b0;
        e_brk    = 1'b0;
        e_st     = 1'b0;
        st_bytes = 0;
        e_data   = '0;
        e_npc    = spc + 64'd4;
        case (opc)
            7'b0110011, 7'b0111011: begin
                e_wen = 1'b1;
                if (f3 == 3'b000 && f7 == 7'b0000000) begin
                    e_data = a + b;
                end else if (f3 == 3'b000 && f7 == 7'b0100000 && opc == 7'b0110011) begin
                    e_data = a - b;
                end else begin
                    e_ill = 1'b1;
                end
                if (opc == 7'b0111011) begin
                    e_data = sext32(e_data);                // addw
                end
            end
            7'b0010011: begin
                e_wen = 1'b1;
                if (f3 == 3'b000) begin
                    e_data = a + immi;
                end else if (f3 == 3'b011) begin
                    e_data = {63'b0, a < immi};
                end else if (f3 == 3'b101 && f7[6:1] == 6'b010000) begin
                    e_data = $signed(a) >>> inst[25:20];
                end else begin
                    e_ill = 1'b1;
                end
            end
            7'b0011011: begin
                e_wen  = 1'b1;
                e_ill  = (f3 != 3'b000);
                e_data = sext32(a + immi);
            end
            7'b0000011: begin
                e_wen  = 1'b1;
                e_ill  = (f3 != 3'b010 && f3 != 3'b011);
                e_data = (f3 == 3'b010) ? sext32(read_dword(ea)) : read_dword(ea);
            end
            7'b0100011: begin
                e_st     = (f3 == 3'b001 || f3 == 3'b011);
                e_ill    = !e_st;
                st_bytes = (f3 == 3'b001) ? 2 : 8;
            end
            7'b1100011: begin
                e_ill = (f3[2:1] != 2'b00);
                if (!e_ill && ((a == b) ^ f3[0])) begin
                    e_npc = spc + immb;
                end
            end
            7'b1101111: begin
                e_wen  = 1'b1;
                e_data = spc + 64'd4;
                e_npc  = spc + immj;
            end
            7'b1100111: begin
                e_wen  = 1'b1;
                e_ill  = (f3 != 3'b000);
                e_data = spc + 64'd4;
                e_npc  = (a + immi) & ~64'd1;
            end
            7'b0110111: begin
                e_wen  = 1'b1;
                e_data = immu;
            end
            7'b0010111: begin
                e_wen  = 1'b1;
                e_data = spc + immu;
            end
            7'b1110011: begin
                e_brk = (inst == 32'h0010_0073);
                e_ill = !e_brk;
            end
            default: e_ill = 1'b1;
        endcase
        e_valid = e_wen && rd != 5'd0 && !e_ill && !shalt;
    end

    always @(posedge clk) begin
        was_reset <= !rst_n;
        if (!rst_n) begin
            for (int i = 0; i < `NREGS; i++) begin
                sregs[i] <= '0;
            end
            spc   <= `RESET_PC;
            shalt <= 1'b0;
        end else if (!shalt) begin
            if (e_ill || e_brk) begin
                shalt <= 1'b1;
            end else begin
                if (e_valid) begin
                    sregs[rd] <= e_data;
                end
                if (e_st) begin
                    for (int k = 0; k < 8; k++) begin
                        if (k < st_bytes) begin
                            smem[MAW'(ea + 64'(k))] <= b[k*8 +: 8];
                        end
                    end
                end
                spc <= e_npc;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !illegal && !retire_valid)
        else begin
            $display("illegal or retire_valid went high while reset was held");
            errors++;
        end

    a_pc: assert property (@(posedge clk) (rst_n || was_reset) |-> pc == spc)
        else begin
            $display("ERR pc exp %h got %h", $sampled(spc), $sampled(pc));
            errors++;
        end

    a_halted: assert property (@(posedge clk) (rst_n || was_reset) |-> halted == shalt)
        else begin
            $display("ERR halted exp %h got %h", $sampled(shalt), $sampled(halted));
            errors++;
        end

    a_illegal: assert property (@(posedge clk) rst_n |-> illegal == e_ill)
        else begin
            $display("ERR illegal exp %h got %h", $sampled(e_ill), $sampled(illegal));
            errors++;
        end

    a_retire_valid: assert property (@(posedge clk) rst_n |-> retire_valid == e_valid)
        else begin
            $display("ERR retire_valid exp %h got %h", $sampled(e_valid),
                     $sampled(retire_valid));
            errors++;
        end

    a_retire_rd: assert property (@(posedge clk) rst_n && retire_valid |-> retire_rd == rd)
        else begin
            $display("ERR retire_rd exp %h got %h", $sampled(rd), $sampled(retire_rd));
            errors++;
        end

    a_retire_data: assert property (
        @(posedge clk) rst_n && retire_valid |-> retire_data == e_data
    ) else begin
        $display("ERR retire_data exp %h got %h", $sampled(e_data), $sampled(retire_data));
        errors++;
    end

endmodule

// File: tb_top.sv
`include "rv_cfg.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] EBREAK       = 32'h0010_0073;
    localparam int          PROG_WORDS   = 64;
    localparam int          HALT_TIMEOUT = 200;       // cycles
    localparam int          OPC_LOAD     = 'h03;
    localparam int          OPC_IMM      = 'h13;
    localparam int          OPC_AUIPC    = 'h17;
    localparam int          OPC_IMMW     = 'h1b;
    localparam int          OPC_REG      = 'h33;
    localparam int          OPC_LUI      = 'h37;
    localparam int          OPC_REGW     = 'h3b;
    localparam int          OPC_JALR     = 'h67;

    logic             clk;
    logic             rst_n;
    logic [31:0]      inst;
    logic [`XLEN-1:0] pc;
    logic             halted;
    logic             illegal;
    logic             retire_valid;
    logic [4:0]       retire_rd;
    logic [`XLEN-1:0] retire_data;
    int               errors;
    logic [31:0]      prog [PROG_WORDS];
    logic [31:0]      code [$];
    int               seed;
    int               n_pass;
    int               n_fail;

    rv_core u_rv_core (
        .clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .halted(halted),
        .illegal(illegal), .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    tb_model u_model (
        .clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .halted(halted),
        .illegal(illegal), .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data), .errors(errors)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    assign inst = prog[pc[7:2]];                     // combinational fetch

    task automatic r_insn(input int f7, input int rs2, input int rs1, input int f3,
                          input int rd, input int op);
        code.push_back({7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'(op)});
    endtask

    task automatic i_insn(input int imm, input int rs1, input int f3, input int rd,
                          input int op);
        code.push_back({12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(op)});
    endtask

    task automatic s_insn(input int imm, input int rs2, input int rs1, input int f3);
        logic [11:0] v;
        v = 12'(imm);
        code.push_back({v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], 7'b0100011});
    endtask

    task automatic b_insn(input int off, input int rs2, input int rs1, input int f3);
        logic [12:0] v;
        v = 13'(off);
        code.push_back({v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], 7'b1100011});
    endtask

    task automatic u_insn(input int imm20, input int rd, input int op);
        code.push_back({20'(imm20), 5'(rd), 7'(op)});
    endtask

    task automatic j_insn(input int off, input int rd);
        logic [20:0] v;
        v = 21'(off);
        code.push_back({v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111});
    endtask

    // lui then addi with the upper part rounded for the signed low 12 bits
    task automatic load_const(input int rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        u_insn(int'(hi[31:12]), rd, OPC_LUI);
        i_insn(int'(v[11:0]), rd, 0, rd, OPC_IMM);
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_program(input string name, input bit expect_illegal);
        int  start_errors;
        int  cyc;
        bit  timed_out;
        start_errors = errors;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        wait_cycle();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = (i < code.size()) ? code[i] : EBREAK;
        end
        repeat (9) wait_cycle();
        rst_n = 1'b1;
        if (expect_illegal) begin
            cyc = 0;
            while (!illegal && cyc < HALT_TIMEOUT) begin
                wait_cycle();
                cyc++;
            end
            if (!illegal) begin
                $display("%s: illegal never rose within %0d cycles", name, HALT_TIMEOUT);
                timed_out = 1'b1;
            end
        end
        cyc = 0;
        while (!halted && cyc < HALT_TIMEOUT) begin
            wait_cycle();
            cyc++;
        end
        if (!halted) begin
            $display("%s: halted never rose within %0d cycles", name, HALT_TIMEOUT);
            timed_out = 1'b1;
        end
        repeat (4) wait_cycle();                     // frozen state after the stop
        if (!timed_out && errors == start_errors) begin
            $display("%-14s pass", name);
            n_pass++;
        end else begin
            $display("%-14s FAIL (%0d errors)", name, errors - start_errors);
            n_fail++;
        end
        code.delete();
    endtask

    task automatic reset_and_ebreak();
        for (int i = 1; i < 7; i++) begin
            i_insn(i * 3, i - 1, 0, i, OPC_IMM);
        end
        code.push_back(EBREAK);
        i_insn(1, 0, 0, 9, OPC_IMM);                 // never reached
        run_program("reset_ebreak", 1'b0);
    endtask

    task automatic arith_ops();
        logic [31:0] r;
        load_const(1, $random(seed));
        load_const(2, $random(seed));
        r_insn('h00, 2, 1, 0, 3, OPC_REG);
        r_insn('h20, 2, 1, 0, 4, OPC_REG);
        r = $random(seed);
        i_insn(int'(r[11:0]), 1, 0, 5, OPC_IMM);
        i_insn(int'(r[23:12]), 1, 3, 6, OPC_IMM);    // sltiu
        i_insn('hfff, 1, 3, 7, OPC_IMM);
        i_insn('h400 | int'(r[29:24]), 1, 5, 8, OPC_IMM);
        i_insn('h400 | 63, 2, 5, 12, OPC_IMM);
        r_insn('h00, 2, 1, 0, 9, OPC_REGW);
        i_insn(int'(r[31:20]), 1, 0, 10, OPC_IMMW);
        r_insn('h00, 2, 1, 0, 0, OPC_REG);           // write to x0
        i_insn(0, 0, 0, 11, OPC_IMM);
        run_program("arith", 1'b0);
    endtask

    task automatic mem_access();
        i_insn(256, 0, 0, 10, OPC_IMM);
        load_const(1, $random(seed));
        load_const(2, $random(seed));
        s_insn(0, 1, 10, 3);
        s_insn(8, 2, 10, 3);
        s_insn(2, 2, 10, 1);                         // sh inside the first dword
        s_insn(14, 1, 10, 1);
        i_insn(0, 10, 3, 3, OPC_LOAD);
        i_insn(0, 10, 2, 4, OPC_LOAD);
        i_insn(4, 10, 2, 5, OPC_LOAD);
        i_insn(8, 10, 3, 6, OPC_LOAD);
        i_insn(12, 10, 2, 7, OPC_LOAD);
        run_program("load_store", 1'b0);
    endtask

    task automatic control_flow();
        i_insn(5, 0, 0, 1, OPC_IMM);
        i_insn(5, 0, 0, 2, OPC_IMM);
        b_insn(8, 2, 1, 0);                          // beq taken
        i_insn(1, 0, 0, 3, OPC_IMM);
        b_insn(8, 2, 1, 1);                          // bne not taken
        i_insn(2, 0, 0, 4, OPC_IMM);
        b_insn(8, 0, 1, 1);                          // bne taken
        i_insn(3, 0, 0, 5, OPC_IMM);
        b_insn(8, 0, 1, 0);                          // beq not taken
        u_insn('h12345, 6, OPC_AUIPC);
        j_insn(8, 7);
        i_insn(4, 0, 0, 8, OPC_IMM);
        i_insn(65, 0, 0, 9, OPC_IMM);                // odd target drops bit 0
        i_insn(0, 9, 0, 10, OPC_JALR);
        i_insn(1, 0, 0, 11, OPC_IMM);
        i_insn(2, 0, 0, 11, OPC_IMM);
        i_insn(3, 0, 0, 13, OPC_IMM);
        i_insn(-1, 13, 0, 13, OPC_IMM);
        b_insn(-4, 0, 13, 1);                        // backward loop
        run_program("control_flow", 1'b0);
    endtask

    task automatic illegal_opcode();
        code.push_back(32'h0000_00ff);               // opcode 7f with rd x1 at the reset pc
        i_insn(7, 0, 0, 2, OPC_IMM);                 // never reached
        run_program("illegal_op", 1'b1);
    endtask

    initial begin
        seed   = 22;
        n_pass = 0;
        n_fail = 0;
        rst_n  = 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = EBREAK;
        end
        reset_and_ebreak();
        arith_ops();
        mem_access();
        control_flow();
        illegal_opcode();
        $display("tests passed %0d, failed %0d, assertion errors %0d", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
